// ==== hdl/rw_pkg.sv ====
package rw_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Sizes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int N_THREADS         = 8;   // One outstanding read each
   localparam int LOG_CQ_SLICE_SIZE = 4;
   localparam int LOG_RW_WIDTH      = 2;   // Object is 4 bytes
   localparam int LOG_LINE_BYTES    = 6;   // 64-byte memory line
   localparam int LOG_OBJS_PER_LINE = LOG_LINE_BYTES - LOG_RW_WIDTH;
   localparam int OUT_LOG_DEPTH     = 4;
   localparam int AR_LOG_DEPTH      = 3;   // 8-entry request queue

   typedef logic [$clog2(N_THREADS)-1:0]      thread_id_t;
   typedef logic [LOG_CQ_SLICE_SIZE-1:0]      cq_slot_t;
   typedef logic [8*(2**LOG_RW_WIDTH)-1:0]    object_t;
   typedef logic [8*(2**LOG_LINE_BYTES)-1:0]  line_t;
   typedef logic [11:0]                       cache_addr_t;
   typedef logic [OUT_LOG_DEPTH:0]            fifo_size_t;   // 0 to 16
   typedef logic [7:0]                        reg_addr_t;

   typedef enum logic [3:0] {
      TASK_TYPE_NORMAL           = 4'd0,
      TASK_TYPE_UNDO_LOG_RESTORE = 4'd1
   } task_type_t;

   typedef struct packed {
      logic [31:0] ts;
      logic [31:0] locale;
      task_type_t  ttype;
      logic        no_read;
   } task_t;

   // Result handed to the output queue
   typedef struct packed {
      task_t       task_desc;
      cq_slot_t    cq_slot;
      thread_id_t  thread;
      object_t     object;
      cache_addr_t cache_addr;
   } rw_write_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Register bus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef struct packed {
      logic        wvalid;   // One-cycle strobe
      reg_addr_t   waddr;
      logic [31:0] wdata;
   } reg_wr_t;

   typedef struct packed {
      logic      arvalid;    // Data follows one cycle later
      reg_addr_t araddr;
   } reg_rd_t;

   localparam reg_addr_t RW_BASE_ADDR                        = 8'h00;
   localparam reg_addr_t CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD = 8'h04;
   localparam reg_addr_t CORE_N_DEQUEUES                     = 8'h08;
   localparam reg_addr_t CORE_START                          = 8'h0C;
   localparam reg_addr_t CORE_DEBUG_WORD                     = 8'h10;

   // Read-only stall counters
   localparam reg_addr_t CNT_NO_TASK    = 8'h80;
   localparam reg_addr_t CNT_PROCESSED  = 8'h84;
   localparam reg_addr_t CNT_STALL_FIFO = 8'h88;
   localparam reg_addr_t CNT_STALL_MEM  = 8'h8C;
   localparam reg_addr_t CNT_UNASSIGNED = 8'hA0;

endpackage

// ==== hdl/fifo.sv ====
`timescale 1ns/10ps

module fifo #(
   parameter int WIDTH     = 32,
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 wr_en,
   input  logic [WIDTH-1:0]     wr_data,

   input  logic                 rd_en,
   output logic [WIDTH-1:0]     rd_data,

   output logic                 full,
   output logic                 empty,
   output logic [LOG_DEPTH:0]   occupancy
);

   localparam int DEPTH = 2**LOG_DEPTH;

   logic [WIDTH-1:0] mem [DEPTH];

   // Extra top bit tells full from empty
   logic [LOG_DEPTH:0] wr_ptr;
   logic [LOG_DEPTH:0] rd_ptr;

   logic do_wr;
   logic do_rd;

   assign occupancy = wr_ptr - rd_ptr;
   assign full      = (occupancy == DEPTH[LOG_DEPTH:0]);
   assign empty     = (wr_ptr == rd_ptr);

   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];   // Head entry

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

// ==== hdl/read_rw.sv ====
`timescale 1ns/10ps

module read_rw (
   input  logic                  clk,
   input  logic                  rstn,

   input  logic                  task_in_valid,
   output logic                  task_in_ready,
   input  rw_pkg::task_t         task_in,
   input  rw_pkg::cq_slot_t      cq_slot_in,
   input  rw_pkg::thread_id_t    thread_id_in,

   input  logic                  gvt_task_slot_valid,
   input  rw_pkg::cq_slot_t      gvt_task_slot,

   output logic                  arvalid,
   input  logic                  arready,
   output logic [31:0]           araddr,
   output rw_pkg::thread_id_t    arid,

   input  logic                  rvalid,
   output logic                  rready,
   input  rw_pkg::thread_id_t    rid,
   input  rw_pkg::line_t         rdata,
   input  rw_pkg::cache_addr_t   rindex,

   output logic                  task_out_valid,
   input  logic                  task_out_ready,
   output rw_pkg::rw_write_t     task_out,
   input  rw_pkg::fifo_size_t    task_out_fifo_occ,

   input  rw_pkg::reg_wr_t       reg_wr,
   input  rw_pkg::reg_rd_t       reg_rd,
   output logic                  reg_rvalid,
   output logic [31:0]           reg_rdata
);

   import rw_pkg::*;

   // Config state
   logic        started;
   logic [31:0] base_rw_addr;
   fifo_size_t  almost_full_thresh;
   logic [31:0] dequeues_remaining;

   logic in_fire;
   logic out_fire;
   logic is_bypass;   // no_read or undo-log restore
   logic can_dequeue;

   // Bypass register
   logic       byp_valid;
   task_t      byp_task;
   cq_slot_t   byp_slot;
   thread_id_t byp_thread;
   object_t    byp_object;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Intake
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   logic        ar_full;
   logic        ar_empty;
   logic        ar_wr;
   logic [31:0] ar_addr_in;

   assign is_bypass = task_in.no_read | (task_in.ttype == TASK_TYPE_UNDO_LOG_RESTORE);

   assign can_dequeue = (dequeues_remaining != '0) &
      ((task_out_fifo_occ < almost_full_thresh) |
       (gvt_task_slot_valid & (gvt_task_slot == cq_slot_in)));

   assign task_in_ready = can_dequeue & ~byp_valid & (is_bypass | ~ar_full);
   assign in_fire       = task_in_valid & task_in_ready;

   assign ar_wr      = in_fire & ~is_bypass;
   assign ar_addr_in = base_rw_addr + (task_in.locale << LOG_RW_WIDTH);

   fifo #(
      .WIDTH     ($bits(ar_addr_in) + $bits(thread_id_t)),
      .LOG_DEPTH (AR_LOG_DEPTH)
   ) u_ar_fifo (
      .clk       (clk),
      .rstn      (rstn),
      .wr_en     (ar_wr),
      .wr_data   ({ar_addr_in, thread_id_in}),
      .rd_en     (arvalid & arready),
      .rd_data   ({araddr, arid}),
      .full      (ar_full),
      .empty     (ar_empty),
      .occupancy ()
   );

   assign arvalid = ~ar_empty;

   // Per-thread context for matching responses
   task_t    thr_task [N_THREADS];
   cq_slot_t thr_slot [N_THREADS];

   always_ff @(posedge clk) begin
      if (ar_wr) begin
         thr_task[thread_id_in] <= task_in;
         thr_slot[thread_id_in] <= cq_slot_in;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Undo log and bypass
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   object_t undo_log [2**LOG_CQ_SLICE_SIZE];
   object_t undo_word;

   assign out_fire = task_out_valid & task_out_ready;

   // Forward an object being logged to the same slot this cycle
   assign undo_word = (out_fire && task_out.cq_slot == cq_slot_in) ?
                      task_out.object : undo_log[cq_slot_in];

   always_ff @(posedge clk) begin
      if (out_fire) begin
         undo_log[task_out.cq_slot] <= task_out.object;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire & is_bypass) begin
         byp_task   <= task_in;
         byp_slot   <= cq_slot_in;
         byp_thread <= thread_id_in;
         byp_object <= (task_in.ttype == TASK_TYPE_UNDO_LOG_RESTORE) ? undo_word : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         byp_valid <= 1'b0;
      end else if (in_fire & is_bypass) begin
         byp_valid <= 1'b1;
      end else if (out_fire) begin
         byp_valid <= 1'b0;
      end
   end

   // Bypass wins over a waiting response
   always_comb begin
      task_out_valid = byp_valid | rvalid;
      rready         = ~byp_valid & task_out_ready;
      if (byp_valid) begin
         task_out.task_desc  = byp_task;
         task_out.cq_slot    = byp_slot;
         task_out.thread     = byp_thread;
         task_out.object     = byp_object;
         task_out.cache_addr = '0;
      end else begin
         task_out.task_desc  = thr_task[rid];
         task_out.cq_slot    = thr_slot[rid];
         task_out.thread     = rid;
         task_out.object     =
            rdata[thr_task[rid].locale[LOG_OBJS_PER_LINE-1:0] * $bits(object_t)
                  +: $bits(object_t)];
         task_out.cache_addr = rindex;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Registers and stall counters
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_rw_addr       <= '0;
         almost_full_thresh <= '1;
         dequeues_remaining <= '1;
         started            <= 1'b0;
      end else if (reg_wr.wvalid) begin
         case (reg_wr.waddr)
            RW_BASE_ADDR:    base_rw_addr <= {reg_wr.wdata[29:0], 2'b00};
            CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD:
               almost_full_thresh <= reg_wr.wdata[$bits(fifo_size_t)-1:0];
            CORE_N_DEQUEUES: dequeues_remaining <= reg_wr.wdata;
            CORE_START:      started <= reg_wr.wdata[0];
            default: ;
         endcase
      end else if (in_fire) begin
         dequeues_remaining <= dequeues_remaining - 1'b1;
      end
   end

   logic [31:0] cnt_no_task;
   logic [31:0] cnt_processed;
   logic [31:0] cnt_stall_fifo;
   logic [31:0] cnt_stall_mem;
   logic [31:0] cnt_unassigned;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cnt_no_task    <= '0;
         cnt_processed  <= '0;
         cnt_stall_fifo <= '0;
         cnt_stall_mem  <= '0;
         cnt_unassigned <= '0;
      end else if (started) begin
         if (!task_in_valid) begin
            cnt_no_task <= cnt_no_task + 1'b1;
         end else if (task_in_ready) begin
            cnt_processed <= cnt_processed + 1'b1;
         end else if (task_out_fifo_occ >= almost_full_thresh) begin
            cnt_stall_fifo <= cnt_stall_fifo + 1'b1;
         end else if (arvalid & ~arready) begin
            cnt_stall_mem <= cnt_stall_mem + 1'b1;
         end else begin
            cnt_unassigned <= cnt_unassigned + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_rd.arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_rd.arvalid) begin
         case (reg_rd.araddr)
            RW_BASE_ADDR:    reg_rdata <= base_rw_addr;
            CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD:
               reg_rdata <= 32'(almost_full_thresh);
            CORE_N_DEQUEUES: reg_rdata <= dequeues_remaining;
            CORE_START:      reg_rdata <= {31'b0, started};
            CORE_DEBUG_WORD: reg_rdata <= {24'b0,
                                           arvalid, arready, rvalid, rready,
                                           task_in_valid, task_in_ready,
                                           task_out_valid, task_out_ready};
            CNT_NO_TASK:     reg_rdata <= cnt_no_task;
            CNT_PROCESSED:   reg_rdata <= cnt_processed;
            CNT_STALL_FIFO:  reg_rdata <= cnt_stall_fifo;
            CNT_STALL_MEM:   reg_rdata <= cnt_stall_mem;
            CNT_UNASSIGNED:  reg_rdata <= cnt_unassigned;
            default:         reg_rdata <= '0;
         endcase
      end
   end

endmodule

// ==== hdl/rw_read_unit.sv ====
`timescale 1ns/10ps

module rw_read_unit (
   input  logic                  clk,
   input  logic                  rstn,

   input  logic                  task_in_valid,
   output logic                  task_in_ready,
   input  rw_pkg::task_t         task_in,
   input  rw_pkg::cq_slot_t      cq_slot_in,
   input  rw_pkg::thread_id_t    thread_id_in,

   input  logic                  gvt_task_slot_valid,
   input  rw_pkg::cq_slot_t      gvt_task_slot,

   output logic                  arvalid,
   input  logic                  arready,
   output logic [31:0]           araddr,
   output rw_pkg::thread_id_t    arid,

   input  logic                  rvalid,
   output logic                  rready,
   input  rw_pkg::thread_id_t    rid,
   input  rw_pkg::line_t         rdata,
   input  rw_pkg::cache_addr_t   rindex,

   output logic                  out_valid,
   input  logic                  out_ready,
   output rw_pkg::rw_write_t     out_word,

   input  rw_pkg::reg_wr_t       reg_wr,
   input  rw_pkg::reg_rd_t       reg_rd,
   output logic                  reg_rvalid,
   output logic [31:0]           reg_rdata
);

   import rw_pkg::*;

   logic       task_out_valid;
   logic       task_out_ready;
   rw_write_t  task_out;
   fifo_size_t out_occ;
   logic       out_full;
   logic       out_empty;

   assign task_out_ready = ~out_full;
   assign out_valid      = ~out_empty;

   read_rw u_read_rw (
      .clk                 (clk),
      .rstn                (rstn),
      .task_in_valid       (task_in_valid),
      .task_in_ready       (task_in_ready),
      .task_in             (task_in),
      .cq_slot_in          (cq_slot_in),
      .thread_id_in        (thread_id_in),
      .gvt_task_slot_valid (gvt_task_slot_valid),
      .gvt_task_slot       (gvt_task_slot),
      .arvalid             (arvalid),
      .arready             (arready),
      .araddr              (araddr),
      .arid                (arid),
      .rvalid              (rvalid),
      .rready              (rready),
      .rid                 (rid),
      .rdata               (rdata),
      .rindex              (rindex),
      .task_out_valid      (task_out_valid),
      .task_out_ready      (task_out_ready),
      .task_out            (task_out),
      .task_out_fifo_occ   (out_occ),
      .reg_wr              (reg_wr),
      .reg_rd              (reg_rd),
      .reg_rvalid          (reg_rvalid),
      .reg_rdata           (reg_rdata)
   );

   // Output queue
   fifo #(
      .WIDTH     ($bits(rw_write_t)),
      .LOG_DEPTH (OUT_LOG_DEPTH)
   ) u_out_fifo (
      .clk       (clk),
      .rstn      (rstn),
      .wr_en     (task_out_valid),
      .wr_data   (task_out),
      .rd_en     (out_ready),
      .rd_data   (out_word),
      .full      (out_full),
      .empty     (out_empty),
      .occupancy (out_occ)
   );

endmodule

// ==== tb/rw_tests.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic step();   // To 1 ns past the next rising edge
   @(posedge clk);
   #1;
endtask

task automatic check_value(input string test_name, input string field,
                           input logic [127:0] expected, input logic [127:0] actual);
   checks++;
   assert (actual === expected) else begin
      errors++;
      $display("mismatch %s %s: expected %0h actual %0h", test_name, field, expected, actual);
   end
endtask

task automatic check_true(input logic cond, input string what);
   checks++;
   assert (cond) else begin
      errors++;
      $display("error: %s", what);
   end
endtask

function automatic task_t make_task(input logic [31:0] ts, input logic [31:0] locale,
                                    input task_type_t ttype, input logic no_read);
   task_t t;
   t.ts      = ts;
   t.locale  = locale;
   t.ttype   = ttype;
   t.no_read = no_read;
   return t;
endfunction

task automatic reg_write(input reg_addr_t addr, input logic [31:0] data);
   reg_wr.wvalid = 1'b1;
   reg_wr.waddr  = addr;
   reg_wr.wdata  = data;
   step();
   reg_wr.wvalid = 1'b0;
endtask

task automatic reg_read(input reg_addr_t addr, output logic [31:0] data);
   reg_rd.arvalid = 1'b1;
   reg_rd.araddr  = addr;
   #2;
   check_true(!reg_rvalid, "register read valid was high before the strobe");
   step();
   reg_rd.arvalid = 1'b0;
   check_true(reg_rvalid, "register read data did not follow one cycle after the strobe");
   data = reg_rdata;
   step();
endtask

// Offer a task until it is taken or the limit runs out
task automatic send_task(input task_t t, input cq_slot_t slot, input thread_id_t thr,
                         input int limit, output logic accepted);
   task_in_valid = 1'b1;
   task_in       = t;
   cq_slot_in    = slot;
   thread_id_in  = thr;
   accepted      = 1'b0;
   for (int i = 0; i < limit && !accepted; i++) begin
      #2;
      accepted = task_in_ready;
      step();
   end
   task_in_valid = 1'b0;
endtask

task automatic wait_outputs(input int n, input string test_name);
   int cycles;
   cycles = 0;
   while (received.size() < n && cycles < 200) begin
      step();
      cycles++;
   end
   check_true(received.size() >= n, {test_name, ": timed out waiting for results"});
endtask

task automatic check_ids(input string test_name, input rw_write_t w, input task_t t,
                         input cq_slot_t slot, input thread_id_t thr);
   check_value(test_name, "task", 128'(t), 128'(w.task_desc));
   check_value(test_name, "slot", 128'(slot), 128'(w.cq_slot));
   check_value(test_name, "thread", 128'(thr), 128'(w.thread));
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic read_path_test();
   task_t       sent [4];
   logic [31:0] locale [4];
   logic [31:0] base;
   logic [31:0] addr;
   logic        acc;
   logic [3:0]  seen;
   int          k;
   locale[0] = 32'd5;
   locale[1] = 32'd18;
   locale[2] = 32'd37;
   locale[3] = 32'd290;
   received.delete();
   req_log.delete();
   reg_write(RW_BASE_ADDR, 32'h0000_0400);
   base = {30'h0000_0400, 2'b00};   // Line aligned
   for (int i = 0; i < 4; i++) begin
      sent[i] = make_task(32'd100 + i, locale[i], TASK_TYPE_NORMAL, 1'b0);
      send_task(sent[i], 4'(i + 1), 3'(i), 50, acc);
      check_true(acc, "read path task was not accepted");
   end
   wait_outputs(4, "read_path");
   check_value("read_path", "requests", 128'(4), 128'(req_log.size()));
   for (int i = 0; i < req_log.size() && i < 4; i++) begin
      check_value("read_path", "araddr", 128'(base + (locale[i] << 2)), 128'(req_log[i].addr));
      check_value("read_path", "arid", 128'(i), 128'(req_log[i].id));
   end
   seen = '0;
   for (int i = 0; i < received.size(); i++) begin
      k = int'(received[i].thread);
      if (k > 3) begin
         check_true(1'b0, "read path result came back on an unused thread");
      end else begin
         check_true(!seen[k], "read path result came back twice for one thread");
         seen[k] = 1'b1;
         addr = base + (locale[k] << 2);
         check_ids("read_path", received[i], sent[k], 4'(k + 1), 3'(k));
         check_value("read_path", "object", 128'(line_word(addr >> 6, locale[k][3:0])),
                     128'(received[i].object));
         check_value("read_path", "rindex", 128'(addr[17:6]), 128'(received[i].cache_addr));
      end
   end
   check_value("read_path", "threads", 128'(4'hF), 128'(seen));
endtask

task automatic no_read_test();
   task_t t;
   logic  acc;
   received.delete();
   req_log.delete();
   t = make_task(32'd200, 32'd999, TASK_TYPE_NORMAL, 1'b1);
   send_task(t, 4'd5, 3'd6, 50, acc);
   check_true(acc, "no-read task was not accepted");
   wait_outputs(1, "no_read");
   if (received.size() > 0) begin
      check_ids("no_read", received[0], t, 4'd5, 3'd6);
   end
   check_value("no_read", "requests", 128'(0), 128'(req_log.size()));
endtask

task automatic undo_restore_test();
   task_t       t;
   logic [31:0] addr;
   logic [31:0] v;
   logic        acc;
   received.delete();
   req_log.delete();
   addr = 32'h0000_1000 + (32'd77 << 2);
   v    = line_word(addr >> 6, 4'(77));   // Object logged for slot 7
   t = make_task(32'd300, 32'd77, TASK_TYPE_NORMAL, 1'b0);
   send_task(t, 4'd7, 3'd4, 50, acc);
   check_true(acc, "read task ahead of the undo-log restore was not accepted");
   wait_outputs(1, "undo_restore");
   t = make_task(32'd301, 32'd77, TASK_TYPE_UNDO_LOG_RESTORE, 1'b0);
   send_task(t, 4'd7, 3'd5, 50, acc);
   check_true(acc, "undo-log restore task was not accepted");
   wait_outputs(2, "undo_restore");
   if (received.size() > 1) begin
      check_ids("undo_restore", received[1], t, 4'd7, 3'd5);
      check_value("undo_restore", "object", 128'(v), 128'(received[1].object));
   end
   check_value("undo_restore", "requests", 128'(1), 128'(req_log.size()));
endtask

task automatic budget_test();
   task_t t;
   logic  acc;
   int    n_acc;
   received.delete();
   n_acc = 0;
   reg_write(CORE_N_DEQUEUES, 32'd3);
   for (int i = 0; i < 5; i++) begin
      t = make_task(32'd400 + i, 32'(i), TASK_TYPE_NORMAL, 1'b1);
      send_task(t, 4'(i), 3'(i), 20, acc);
      if (acc) begin
         n_acc++;
      end
   end
   check_value("budget", "accepted", 128'(3), 128'(n_acc));
   reg_write(CORE_N_DEQUEUES, 32'd8);
   for (int i = 3; i < 5; i++) begin
      t = make_task(32'd400 + i, 32'(i), TASK_TYPE_NORMAL, 1'b1);
      send_task(t, 4'(i), 3'(i), 20, acc);
      check_true(acc, "task after budget reload was not accepted");
   end
   wait_outputs(5, "budget");
   reg_write(CORE_N_DEQUEUES, 32'hFFFF_FFFF);
endtask

task automatic threshold_test();
   task_t t;
   logic  acc;
   int    n_acc;
   received.delete();
   n_acc               = 0;
   out_ready           = 1'b0;   // Let the output queue fill
   gvt_task_slot_valid = 1'b1;
   gvt_task_slot       = 4'd9;
   reg_write(CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD, 32'd2);
   for (int i = 1; i <= 3; i++) begin
      t = make_task(32'd500 + i, 32'(i), TASK_TYPE_NORMAL, 1'b1);
      send_task(t, 4'(i), 3'(i), 20, acc);
      if (acc) begin
         n_acc++;
      end
   end
   check_value("threshold", "accepted", 128'(2), 128'(n_acc));
   t = make_task(32'd509, 32'd9, TASK_TYPE_NORMAL, 1'b1);
   send_task(t, 4'd9, 3'd4, 20, acc);
   check_true(acc, "task on the gvt slot was not accepted past the threshold");
   check_true(out_valid, "no results were queued while the output was held");
   check_value("threshold", "head slot", 128'(1), 128'(out_word.cq_slot));
   out_ready = 1'b1;
   wait_outputs(3, "threshold");
   step();
   check_value("threshold", "results", 128'(3), 128'(received.size()));
   for (int i = 0; i < received.size() && i < 3; i++) begin
      check_value("threshold", "order", 128'((i == 2) ? 9 : i + 1), 128'(received[i].cq_slot));
   end
   gvt_task_slot_valid = 1'b0;
   reg_write(CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD, 32'h1F);
endtask

task automatic counter_test();
   task_t       t;
   logic        acc;
   logic [31:0] v;
   int          n_acc;
   received.delete();
   n_acc = 0;
   reg_write(CORE_START, 32'd1);
   repeat (8) step();   // Idle cycles
   for (int i = 0; i < 4; i++) begin
      t = make_task(32'd600 + i, 32'(i), TASK_TYPE_NORMAL, 1'b1);
      send_task(t, 4'(i), 3'(i), 50, acc);
      if (acc) begin
         n_acc++;
      end
   end
   reg_write(CORE_START, 32'd0);
   wait_outputs(4, "counters");
   check_value("counters", "accepted", 128'(4), 128'(n_acc));
   reg_read(CNT_PROCESSED, v);
   check_value("counters", "processed", 128'(4), 128'(v));
   reg_read(CNT_NO_TASK, v);
   check_true(v != 32'd0, "idle cycle counter stayed at zero");
endtask

// ==== tb/tb_rw_read_unit.sv ====
`timescale 1ns/10ps

module tb_rw_read_unit;

   import rw_pkg::*;

   // Memory request as seen by the responder
   typedef struct packed {
      logic [31:0] addr;
      thread_id_t  id;
      logic [3:0]  delay;
   } mem_req_t;

   logic        clk;
   logic        rstn;
   logic        task_in_valid;
   logic        task_in_ready;
   task_t       task_in;
   cq_slot_t    cq_slot_in;
   thread_id_t  thread_id_in;
   logic        gvt_task_slot_valid;
   cq_slot_t    gvt_task_slot;
   logic        arvalid;
   logic        arready;
   logic [31:0] araddr;
   thread_id_t  arid;
   logic        rvalid;
   logic        rready;
   thread_id_t  rid;
   line_t       rdata;
   cache_addr_t rindex;
   logic        out_valid;
   logic        out_ready;
   rw_write_t   out_word;
   reg_wr_t     reg_wr;
   reg_rd_t     reg_rd;
   logic        reg_rvalid;
   logic [31:0] reg_rdata;

   int          errors = 0;
   int          checks = 0;
   logic [15:0] lfsr_state;
   mem_req_t    pending [$];   // Accepted and not yet answered
   mem_req_t    req_log [$];
   rw_write_t   received [$];

   rw_read_unit u_rw_read_unit (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Memory model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[6:0], lfsr_state[0]};
      end
   endtask

   // Word w of the line at line address a
   function automatic logic [31:0] line_word(input logic [31:0] a, input logic [3:0] w);
      logic [31:0] h;
      h = a * 32'h9E37_79B1;
      h = h ^ ({28'b0, w} * 32'h85EB_CA6B) ^ {w, a[27:0]};
      return h;
   endfunction

   function automatic line_t build_line(input logic [31:0] addr);
      line_t line;
      for (int w = 0; w < 16; w++) begin
         line[w*32 +: 32] = line_word(addr >> 6, 4'(w));
      end
      return line;
   endfunction

   initial begin : memory_model
      logic [7:0] bits;
      int         show_idx;
      logic       r_take;
      mem_req_t   req;
      lfsr_state = 16'd63;
      arready    = 1'b0;
      rvalid     = 1'b0;
      rid        = '0;
      rdata      = '0;
      rindex     = '0;
      show_idx   = -1;
      r_take     = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (r_take) begin
            pending.delete(show_idx);
            show_idx = -1;
         end
         for (int i = 0; i < pending.size(); i++) begin
            if (pending[i].delay != 4'd0) begin
               pending[i].delay = pending[i].delay - 4'd1;
            end
         end
         rand_bits(2, bits);
         arready = (bits[1:0] != 2'b00);   // Stall one cycle in four
         for (int i = 0; i < pending.size(); i++) begin
            if (show_idx < 0 && pending[i].delay == 4'd0) begin
               show_idx = i;
            end
         end
         rvalid = (show_idx >= 0);
         if (show_idx >= 0) begin
            rid    = pending[show_idx].id;
            rdata  = build_line(pending[show_idx].addr);
            rindex = pending[show_idx].addr[17:6];
         end
         #2;
         r_take = rvalid && rready;
         if (arvalid && arready) begin
            rand_bits(3, bits);
            req.addr  = araddr;
            req.id    = arid;
            req.delay = {1'b0, bits[2:0]};
            pending.push_back(req);
            req_log.push_back(req);
         end
      end
   end

   initial begin : output_monitor
      forever begin
         @(posedge clk);
         #3;
         if (rstn && out_valid && out_ready) begin
            received.push_back(out_word);
         end
      end
   end

   `include "rw_tests.svh"

   initial begin
      rstn                = 1'b0;
      task_in_valid       = 1'b0;
      task_in             = '0;
      cq_slot_in          = '0;
      thread_id_in        = '0;
      gvt_task_slot_valid = 1'b0;
      gvt_task_slot       = '0;
      out_ready           = 1'b1;
      reg_wr              = '0;
      reg_rd              = '0;
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;
      step();
      read_path_test();
      no_read_test();
      undo_restore_test();
      budget_test();
      threshold_test();
      counter_test();
      $display("Tests done with %0d checks and %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+tb
hdl/rw_pkg.sv
hdl/fifo.sv
hdl/read_rw.sv
hdl/rw_read_unit.sv
tb/tb_rw_read_unit.sv

// ==== Makefile ====
# Verilator flow for the object-read stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module rw_read_unit -f src.f

# The log is searched for the pass line, so a failing run fails the target
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rw_read_unit \
		-f src.f --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
